// File: logic/dbg_pkg.sv
/*
 * Shared constants and types for the debug subsystem.
 * Imported by wildcard in each module header that needs them.
 */

package dbg_pkg;

  ///////////////////////////////
  // Sizes
  ///////////////////////////////

  // Data word and serial slot width
  localparam int unsigned WORD_W = 32;
  // 256 word debug memory
  localparam int unsigned MEM_AW = 8;
  localparam int unsigned OP_W   = 4;

  ///////////////////////////////
  // Opcodes and status
  ///////////////////////////////

  localparam logic [OP_W-1:0] OP_WRITE = 4'h1;
  localparam logic [OP_W-1:0] OP_READ  = 4'h2;

  // Serial CRC-32, reflected form
  localparam logic [WORD_W-1:0] CRC_INIT      = 32'hffff_ffff;
  localparam logic [WORD_W-1:0] CRC_POLY_REFL = 32'hedb8_8320;

  // Returned in the status slot of a write
  localparam logic [WORD_W-1:0] STATUS_CRC_OK  = 32'd1;
  localparam logic [WORD_W-1:0] STATUS_CRC_BAD = 32'd0;

  ///////////////////////////////
  // Types
  ///////////////////////////////

  // Header layout, opcode in the top nibble
  typedef struct packed {
    logic [OP_W-1:0] opcode;
    logic [3:0]      rsvd;
    logic [7:0]      count;   // words minus one
    logic [15:0]     addr;
  } dbg_hdr_t;

  // One received slot, header or plain data
  typedef union packed {
    dbg_hdr_t          hdr;
    logic [WORD_W-1:0] raw;
  } dbg_word_u;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_DATA,
    ST_WR_CRC,
    ST_WR_STATUS,
    ST_RD_LAT,
    ST_RD_DATA,
    ST_RD_CRC
  } dbg_state_e;

endpackage

// File: logic/mem_if.sv
/*
 * One memory master port. Request fields are held until the one-cycle ack,
 * and rdata is valid together with ack.
 */

`timescale 1ns/1ps

interface mem_if import dbg_pkg::*; ();

  // Master side
  logic              req;
  logic              we;
  logic [MEM_AW-1:0] addr;
  logic [WORD_W-1:0] wdata;

  // Slave side
  logic [WORD_W-1:0] rdata;
  logic              ack;

  modport master (output req, we, addr, wdata, input rdata, ack);
  modport slave (input req, we, addr, wdata, output rdata, ack);

endinterface

// File: logic/dbg_crc32.sv
/*
 * Bit-serial reflected CRC-32. One data bit per enable, shift moves the
 * register right so the value leaves LSB first on serial_out.
 */

`timescale 1ns/1ps

module dbg_crc32 import dbg_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              clr,
  input  logic              enable,
  input  logic              shift,
  input  logic              data,
  output logic [WORD_W-1:0] crc_out,
  output logic              serial_out
);

  ///////////////////////////////
  // Next value
  ///////////////////////////////

  logic [WORD_W-1:0] crc;
  logic [WORD_W-1:0] crc_shr;
  logic [WORD_W-1:0] crc_next;
  logic              fb;

  // Feedback from the bit leaving at the bottom
  assign fb = crc[0] ^ data;

  // Plain right shift, also used for serial output
  assign crc_shr = {1'b0, crc[WORD_W-1:1]};

  // Taps only when feedback is set
  assign crc_next = fb ? (crc_shr ^ CRC_POLY_REFL) : crc_shr;

  ///////////////////////////////
  // Register
  ///////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      crc <= CRC_INIT;
    end else if (clr) begin
      // Clear wins over everything else
      crc <= CRC_INIT;
    end else if (enable) begin
      crc <= crc_next;
    end else if (shift) begin
      crc <= crc_shr;
    end
  end

  assign crc_out    = crc;
  // LSB goes out first
  assign serial_out = crc[0];

endmodule

// File: logic/dbg_shift_port.sv
/*
 * Serial side of the debug port. Assembles 32-bit slots from tdi, LSB first,
 * and shifts the engine's next word out on tdo_word_bit.
 */

`timescale 1ns/1ps

module dbg_shift_port import dbg_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              tdi,
  input  logic              shift_en,
  input  logic [WORD_W-1:0] tx_word,
  output logic              tdo_word_bit,
  output logic              word_done,
  output logic [WORD_W-1:0] rx_word
);

  logic [4:0]        slot_cnt;
  logic [WORD_W-1:0] rx_sr;
  logic [WORD_W-1:0] tx_sr;

  // Last bit of the slot is being shifted now
  assign word_done = shift_en && (slot_cnt == 5'(WORD_W - 1));

  // Full word including the bit on tdi this cycle
  assign rx_word = {tdi, rx_sr[WORD_W-1:1]};

  // Slot position, wraps after 32 shifts
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_cnt <= '0;
    end else if (shift_en) begin
      slot_cnt <= slot_cnt + 5'd1;
    end
  end

  // Receive path, new bits enter at the top
  always_ff @(posedge clk) begin
    if (shift_en) begin
      rx_sr <= rx_word;
    end
  end

  // Transmit path
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_sr <= '0;
    end else if (word_done) begin
      // Reload at the slot boundary
      tx_sr <= tx_word;
    end else if (shift_en) begin
      tx_sr <= {1'b0, tx_sr[WORD_W-1:1]};
    end
  end

  assign tdo_word_bit = tx_sr[0];

endmodule

// File: logic/dbg_burst_engine.sv
/*
 * Transaction FSM of the debug port. Decodes headers, runs write and read
 * bursts against the memory bus, keeps the burst CRC and drives tdo.
 */

`timescale 1ns/1ps

module dbg_burst_engine import dbg_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              tdi,
  input  logic              shift_en,
  input  logic              word_done,
  input  logic [WORD_W-1:0] rx_word,
  input  logic              tdo_word_bit,
  output logic [WORD_W-1:0] tx_word,
  output logic              tdo,
  mem_if.master             bus
);

  ///////////////////////////////
  // Declarations
  ///////////////////////////////

  dbg_state_e        state;
  dbg_word_u         rx_u;
  logic [7:0]        cnt;
  logic              req_q;
  logic              we_q;
  logic [MEM_AW-1:0] addr_q;
  logic [WORD_W-1:0] wdata_q;
  logic [WORD_W-1:0] rd_buf;

  logic              crc_clr;
  logic              crc_en;
  logic              crc_shift;
  logic              crc_data;
  logic [WORD_W-1:0] crc_val;
  logic              crc_bit;

  // Same slot seen as header or as data
  assign rx_u = rx_word;

  ///////////////////////////////
  // CRC control
  ///////////////////////////////

  // Fresh CRC for every header
  assign crc_clr   = word_done && (state == ST_IDLE);
  assign crc_en    = shift_en && ((state == ST_WR_DATA) || (state == ST_RD_DATA));
  assign crc_shift = shift_en && (state == ST_RD_CRC);
  // Writes check tdi, reads cover what goes out on tdo
  assign crc_data  = (state == ST_RD_DATA) ? tdo_word_bit : tdi;

  dbg_crc32 u_crc (
    .clk        (clk),
    .rst        (rst),
    .clr        (crc_clr),
    .enable     (crc_en),
    .shift      (crc_shift),
    .data       (crc_data),
    .crc_out    (crc_val),
    .serial_out (crc_bit)
  );

  // CRC slot of a read comes straight from the CRC register
  assign tdo = (state == ST_RD_CRC) ? crc_bit : tdo_word_bit;

  // Word loaded into the port at this slot boundary
  always_comb begin
    case (state)
      ST_RD_LAT, ST_RD_DATA: tx_word = rd_buf;
      ST_WR_CRC:             tx_word = (rx_u.raw == crc_val) ? STATUS_CRC_OK : STATUS_CRC_BAD;
      default:               tx_word = '0;
    endcase
  end

  ///////////////////////////////
  // FSM and request control
  ///////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_IDLE;
      cnt   <= '0;
      req_q <= 1'b0;
      we_q  <= 1'b0;
    end else begin
      if (bus.ack) begin
        req_q <= 1'b0;
      end
      if (word_done) begin
        case (state)
          ST_IDLE: begin
            // Unknown opcodes leave the engine idle
            if (rx_u.hdr.opcode == OP_WRITE) begin
              state <= ST_WR_DATA;
              cnt   <= rx_u.hdr.count;
            end else if (rx_u.hdr.opcode == OP_READ) begin
              // First fetch runs during the latency slot
              state <= ST_RD_LAT;
              cnt   <= rx_u.hdr.count;
              req_q <= 1'b1;
              we_q  <= 1'b0;
            end
          end
          ST_WR_DATA: begin
            req_q <= 1'b1;
            we_q  <= 1'b1;
            if (cnt == 8'd0) begin
              state <= ST_WR_CRC;
            end else begin
              cnt <= cnt - 8'd1;
            end
          end
          ST_WR_CRC:    state <= ST_WR_STATUS;
          ST_RD_LAT: begin
            // Second word, if any
            if (cnt != 8'd0) begin
              req_q <= 1'b1;
            end
            state <= ST_RD_DATA;
          end
          ST_RD_DATA: begin
            // Prefetch two words ahead of the slot
            if (cnt > 8'd1) begin
              req_q <= 1'b1;
            end
            if (cnt == 8'd0) begin
              state <= ST_RD_CRC;
            end else begin
              cnt <= cnt - 8'd1;
            end
          end
          default:      state <= ST_IDLE;
        endcase
      end
    end
  end

  ///////////////////////////////
  // Address and data
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (bus.ack) begin
      // Wraps modulo 256
      addr_q <= addr_q + 1'b1;
      if (!we_q) begin
        rd_buf <= bus.rdata;
      end
    end
    if (word_done && (state == ST_IDLE)) begin
      addr_q <= rx_u.hdr.addr[MEM_AW-1:0];
    end
    if (word_done && (state == ST_WR_DATA)) begin
      wdata_q <= rx_u.raw;
    end
  end

  assign bus.req   = req_q;
  assign bus.we    = we_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

endmodule

// File: logic/mem_arbiter.sv
/*
 * Round-robin arbiter for two memory masters sharing one memory port.
 * The grant is held through the ack cycle of the access it started.
 */

`timescale 1ns/1ps

module mem_arbiter (
  input  logic  clk,
  input  logic  rst,
  mem_if.slave  dbg_bus,
  mem_if.slave  host_bus,
  mem_if.master mem_bus
);

  // Pointer high favours the host
  logic ptr;
  // Owner of the access now being acked
  logic owner;
  logic pick_host;
  logic sel_host;

  // Host wins when alone or when it is its turn
  assign pick_host = host_bus.req && (!dbg_bus.req || ptr);

  // Keep the owner while the memory acks
  assign sel_host = mem_bus.ack ? owner : pick_host;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ptr   <= 1'b0;
      owner <= 1'b0;
    end else if (mem_bus.ack) begin
      // Next turn to the one not just served
      ptr <= ~owner;
    end else begin
      owner <= pick_host;
    end
  end

  // Forward request fields of the granted master
  assign mem_bus.req   = sel_host ? host_bus.req : dbg_bus.req;
  assign mem_bus.we    = sel_host ? host_bus.we : dbg_bus.we;
  assign mem_bus.addr  = sel_host ? host_bus.addr : dbg_bus.addr;
  assign mem_bus.wdata = sel_host ? host_bus.wdata : dbg_bus.wdata;

  // Return path only to the owner
  assign dbg_bus.ack    = mem_bus.ack && !sel_host;
  assign host_bus.ack   = mem_bus.ack && sel_host;
  assign dbg_bus.rdata  = sel_host ? '0 : mem_bus.rdata;
  assign host_bus.rdata = sel_host ? mem_bus.rdata : '0;

endmodule

// File: logic/dbg_mem.sv
/*
 * 256 x 32 debug memory. Each request is served once and acked a cycle
 * later, with read data alongside the ack.
 */

`timescale 1ns/1ps

module dbg_mem import dbg_pkg::*; (
  input  logic clk,
  input  logic rst,
  mem_if.slave bus
);

  logic [WORD_W-1:0] mem [2**MEM_AW];
  logic              start;

  // Request still high in its ack cycle is not a new one
  assign start = bus.req && !bus.ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= start;
    end
  end

  // Array and read data
  always_ff @(posedge clk) begin
    if (start) begin
      if (bus.we) begin
        mem[bus.addr] <= bus.wdata;
      end
      bus.rdata <= mem[bus.addr];
    end
  end

endmodule

// File: logic/dbg_subsys_top.sv
/*
 * Debug subsystem top. Serial debug pins feed the burst engine, the host
 * port pins form a second master, both share the debug memory.
 */

`timescale 1ns/1ps

module dbg_subsys_top import dbg_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              tdi,
  input  logic              shift_en,
  output logic              tdo,
  input  logic              host_req,
  input  logic              host_we,
  input  logic [MEM_AW-1:0] host_addr,
  input  logic [WORD_W-1:0] host_wdata,
  output logic [WORD_W-1:0] host_rdata,
  output logic              host_ack
);

  ///////////////////////////////
  // Serial side
  ///////////////////////////////

  logic              word_done;
  logic              tdo_word_bit;
  logic [WORD_W-1:0] rx_word;
  logic [WORD_W-1:0] tx_word;

  mem_if dbg_bus ();
  mem_if host_bus ();
  mem_if mem_bus ();

  dbg_shift_port u_shift (
    .clk          (clk),
    .rst          (rst),
    .tdi          (tdi),
    .shift_en     (shift_en),
    .tx_word      (tx_word),
    .tdo_word_bit (tdo_word_bit),
    .word_done    (word_done),
    .rx_word      (rx_word)
  );

  dbg_burst_engine u_engine (
    .clk          (clk),
    .rst          (rst),
    .tdi          (tdi),
    .shift_en     (shift_en),
    .word_done    (word_done),
    .rx_word      (rx_word),
    .tdo_word_bit (tdo_word_bit),
    .tx_word      (tx_word),
    .tdo          (tdo),
    .bus          (dbg_bus.master)
  );

  ///////////////////////////////
  // Memory side
  ///////////////////////////////

  // Host pins as the second master
  assign host_bus.req   = host_req;
  assign host_bus.we    = host_we;
  assign host_bus.addr  = host_addr;
  assign host_bus.wdata = host_wdata;
  assign host_rdata     = host_bus.rdata;
  assign host_ack       = host_bus.ack;

  mem_arbiter u_arb (
    .clk      (clk),
    .rst      (rst),
    .dbg_bus  (dbg_bus.slave),
    .host_bus (host_bus.slave),
    .mem_bus  (mem_bus.master)
  );

  dbg_mem u_mem (
    .clk (clk),
    .rst (rst),
    .bus (mem_bus.slave)
  );

endmodule

// File: tb/tb_dbg_subsys.sv
/*
 * Testbench for the debug subsystem. Applies a table of serial transactions,
 * checks tdo and host port reads against a memory model and a CRC model.
 */

`timescale 1ns/1ps

module tb_dbg_subsys import dbg_pkg::*; ();

  ///////////////////////////////
  // Constants and table
  ///////////////////////////////

  // Reference CRC-32 constants in reflected form
  localparam logic [31:0] REF_POLY    = 32'hedb8_8320;
  localparam logic [31:0] REF_INIT    = 32'hffff_ffff;
  localparam int          ACK_TIMEOUT = 50;
  localparam int          NUM_ROWS    = 8;

  typedef struct packed {
    logic [3:0]  op;
    logic [7:0]  addr;
    logic [7:0]  count;     // words minus one
    logic [31:0] seed;      // mixed into the random data
    logic        bad_crc;
    logic        host;      // host writes run alongside
  } row_t;

  row_t        rows [NUM_ROWS];
  logic [31:0] model [256];

  logic        clk = 1'b0;
  logic        rst;
  logic        tdi;
  logic        shift_en;
  logic        tdo;
  logic        host_req;
  logic        host_we;
  logic [7:0]  host_addr;
  logic [31:0] host_wdata;
  logic [31:0] host_rdata;
  logic        host_ack;

  int err_data;
  int err_crc;
  int err_status;
  int err_host;
  int err_timeout;
  int seed_val;

  dbg_subsys_top DUT (
    .clk        (clk),
    .rst        (rst),
    .tdi        (tdi),
    .shift_en   (shift_en),
    .tdo        (tdo),
    .host_req   (host_req),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .host_ack   (host_ack)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ///////////////////////////////
  // CRC model
  ///////////////////////////////

  // One bit by the shift and tap rule
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic b);
    logic fb;
    fb = c[0] ^ b;
    c  = c >> 1;
    if (fb) begin
      c = c ^ REF_POLY;
    end
    return c;
  endfunction

  // Whole word LSB first as on the wire
  function automatic logic [31:0] crc_word(input logic [31:0] c, input logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      c = crc_step(c, w[i]);
    end
    return c;
  endfunction

  ///////////////////////////////
  // Serial and host drivers
  ///////////////////////////////

  // One 32-bit slot entered and left 2 ns after a rising edge
  task automatic shift_slot(input logic [31:0] din, output logic [31:0] dout);
    int i;
    dout = '0;
    for (i = 0; i < 32; i++) begin
      tdi      = din[i];
      shift_en = 1'b1;
      #1;
      // tdo belongs to the edge that samples this tdi
      dout[i] = tdo;
      @(posedge clk);
      #2;
    end
  endtask

  // Random pause with shift_en low
  task automatic idle_gap();
    int n;
    n        = $urandom_range(0, 2);
    shift_en = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Hold the request until ack or timeout
  task automatic host_access(input logic we, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int   waited;
    logic done;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    waited     = 0;
    done       = 1'b0;
    rdata      = '0;
    while (!done && (waited < ACK_TIMEOUT)) begin
      #1;
      if (host_ack) begin
        rdata = host_rdata;
        done  = 1'b1;
      end
      @(posedge clk);
      #2;
      waited++;
    end
    host_req = 1'b0;
    host_we  = 1'b0;
    assert (done) else begin
      err_timeout++;
      $display("Host port access to address %02h got no ack in %0d cycles", addr, waited);
    end
  endtask

  // Pattern depends on every address bit
  task automatic fill_memory();
    logic [31:0] dummy;
    logic [31:0] w;
    for (int a = 0; a < 256; a++) begin
      w = 32'h9e37_79b9 * (a + 1);
      host_access(1'b1, 8'(a), w, dummy);
      model[a] = w;
    end
  endtask

  // Host reads of a window that wraps at 256
  task automatic check_window(input logic [7:0] start, input int n);
    logic [7:0]  ad;
    logic [31:0] got;
    for (int k = 0; k < n; k++) begin
      ad = start + 8'(k);
      host_access(1'b0, ad, 32'h0, got);
      assert (got === model[ad]) else begin
        err_host++;
        $display("Error: host_rdata at %02h got %08h expected %08h", ad, got, model[ad]);
      end
    end
  endtask

  // Host writes away from the burst windows
  task automatic host_traffic();
    logic [31:0] dummy;
    logic [31:0] w;
    for (int k = 0; k < 6; k++) begin
      w = $urandom;
      host_access(1'b1, 8'hc0 + 8'(k), w, dummy);
      model[8'hc0 + 8'(k)] = w;
    end
  endtask

  ///////////////////////////////
  // Transactions
  ///////////////////////////////

  task automatic serial_xfer(input row_t row);
    int          n;
    logic [7:0]  a;
    logic [31:0] w;
    logic [31:0] crc;
    logic [31:0] dout;
    n   = int'(row.count) + 1;
    crc = REF_INIT;
    shift_slot({row.op, 4'h0, row.count, 8'h00, row.addr}, dout);
    idle_gap();
    if (row.op == OP_WRITE) begin
      for (int k = 0; k < n; k++) begin
        a        = row.addr + 8'(k);
        w        = $urandom ^ row.seed;
        model[a] = w;
        crc      = crc_word(crc, w);
        shift_slot(w, dout);
        idle_gap();
      end
      // Corrupted CRC still writes the data
      shift_slot(row.bad_crc ? (crc ^ 32'h8000_0001) : crc, dout);
      idle_gap();
      shift_slot(32'h0, dout);
      assert (dout === (row.bad_crc ? 32'd0 : 32'd1)) else begin
        err_status++;
        $display("Error: tdo status got %08h expected %08h", dout, row.bad_crc ? 0 : 1);
      end
    end else if (row.op == OP_READ) begin
      shift_slot(32'h0, dout);
      assert (dout === 32'h0) else begin
        err_data++;
        $display("Error: tdo latency slot got %08h expected 00000000", dout);
      end
      idle_gap();
      for (int k = 0; k < n; k++) begin
        a   = row.addr + 8'(k);
        crc = crc_word(crc, model[a]);
        shift_slot(32'h0, dout);
        assert (dout === model[a]) else begin
          err_data++;
          $display("Error: tdo word at %02h got %08h expected %08h", a, dout, model[a]);
        end
        idle_gap();
      end
      shift_slot(32'h0, dout);
      assert (dout === crc) else begin
        err_crc++;
        $display("Error: tdo crc got %08h expected %08h", dout, crc);
      end
    end else begin
      // Zero slots decode as opcode 0 and would be burst data if the header were taken
      for (int k = 0; k < n; k++) begin
        shift_slot(32'h0, dout);
        idle_gap();
      end
    end
    idle_gap();
  endtask

  task automatic run_row(input row_t row);
    if (row.host) begin
      fork
        serial_xfer(row);
        host_traffic();
      join
      check_window(8'hc0, 6);
    end else begin
      serial_xfer(row);
    end
    // Burst window matches the model after writes and ignored headers
    if (row.op != OP_READ) begin
      check_window(row.addr, int'(row.count) + 1);
    end
  endtask

  ///////////////////////////////
  // Main sequence
  ///////////////////////////////

  initial begin
    rst         = 1'b1;
    tdi         = 1'b0;
    shift_en    = 1'b0;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_addr   = '0;
    host_wdata  = '0;
    err_data    = 0;
    err_crc     = 0;
    err_status  = 0;
    err_host    = 0;
    err_timeout = 0;
    seed_val    = $urandom(81);

    rows[0] = '{OP_WRITE, 8'h10, 8'd7, 32'h0000_0000, 1'b0, 1'b0};
    rows[1] = '{OP_WRITE, 8'h20, 8'd3, 32'h5a5a_0f0f, 1'b1, 1'b0};
    rows[2] = '{OP_READ,  8'h10, 8'd7, 32'h0000_0000, 1'b0, 1'b0};
    rows[3] = '{OP_READ,  8'h20, 8'd3, 32'h0000_0000, 1'b0, 1'b1};
    // Wraps past the top of memory
    rows[4] = '{OP_WRITE, 8'hfa, 8'd9, 32'h1234_8765, 1'b0, 1'b0};
    rows[5] = '{OP_READ,  8'hfa, 8'd9, 32'h0000_0000, 1'b0, 1'b0};
    rows[6] = '{4'hf,     8'h10, 8'd7, 32'h0000_0000, 1'b0, 1'b0};
    rows[7] = '{OP_READ,  8'h10, 8'd7, 32'h0000_0000, 1'b0, 1'b0};

    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    fill_memory();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r]);
    end

    $display("Error counts: data %0d, crc %0d, status %0d, host %0d, timeout %0d",
             err_data, err_crc, err_status, err_host, err_timeout);
    if ((err_data + err_crc + err_status + err_host + err_timeout) == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
logic/dbg_pkg.sv
logic/mem_if.sv
logic/dbg_crc32.sv
logic/dbg_shift_port.sv
logic/dbg_burst_engine.sv
logic/mem_arbiter.sv
logic/dbg_mem.sv
logic/dbg_subsys_top.sv
tb/tb_dbg_subsys.sv
